//--- common/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // Byte addresses, 16-bit words on even addresses
   localparam int addr_bits = 16;
   localparam int data_bits = 16;

   // Address split into tag, set index and byte offset in the line
   localparam int tag_bits    = 5;
   localparam int index_bits  = 8;
   localparam int offset_bits = 3;

   localparam int num_sets = 2 ** index_bits;

   // Four words per line, picked by offset bits 2 to 1
   localparam int line_words    = 4;
   localparam int word_sel_bits = offset_bits - 1;

   // Main memory timing
   localparam int mem_read_latency = 2;
   localparam int bank_busy_cycles = 4;

endpackage

`default_nettype wire

//--- common/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

   // Cache controller FSM
   typedef enum logic [4:0] {
      st_idle,
      st_compare,       // repeat compare for a held request
      st_check,         // hit decision on registered flags
      st_evict_check,   // dirty decision on the victim line
      st_wb0,
      st_wb1,
      st_wb2,
      st_rd_start,
      st_rd1,
      st_fill0,         // fill writes overlap the last reads
      st_fill1,
      st_fill2,
      st_fill3,
      st_final_comp,
      st_done
   } ctrl_state_t;

   // Command to main memory
   typedef enum logic [1:0] {
      mem_idle,
      mem_read,
      mem_write
   } mem_cmd_t;

endpackage

`default_nettype wire

//--- cache/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire                                    enable,
   input  wire                                    comp,
   input  wire                                    write,
   input  wire  [cache_geom_pkg::tag_bits-1:0]    tag_in,
   input  wire  [cache_geom_pkg::index_bits-1:0]  index,
   input  wire  [cache_geom_pkg::offset_bits-1:0] offset,
   input  wire  [cache_geom_pkg::data_bits-1:0]   data_in,
   output logic [cache_geom_pkg::data_bits-1:0]   data_out,
   output logic [cache_geom_pkg::tag_bits-1:0]    tag_out,
   output logic                                   hit,
   output logic                                   valid,
   output logic                                   dirty
);

   // Per-line storage
   logic [cache_geom_pkg::tag_bits-1:0]  tag_mem  [cache_geom_pkg::num_sets];
   logic [cache_geom_pkg::data_bits-1:0] data_mem [cache_geom_pkg::num_sets]
                                                   [cache_geom_pkg::line_words];
   logic [cache_geom_pkg::num_sets-1:0]  valid_bits;
   logic [cache_geom_pkg::num_sets-1:0]  dirty_bits;

   logic [cache_geom_pkg::word_sel_bits-1:0] word;
   logic                                     tag_match;
   logic                                     comp_wr;
   logic                                     fill_wr;

   // Byte offset bit 0 is always zero for word accesses
   assign word = offset[cache_geom_pkg::offset_bits-1:1];

   assign tag_match = tag_mem[index] == tag_in;
   assign data_out  = data_mem[index][word];
   assign tag_out   = tag_mem[index];
   assign valid     = valid_bits[index];
   assign dirty     = dirty_bits[index];
   assign hit       = enable & valid & tag_match;

   // Compare write only lands on a hit, access write refills the line
   assign comp_wr = enable & comp & write & hit;
   assign fill_wr = enable & ~comp & write;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         valid_bits[index] <= 1'b1;
         dirty_bits[index] <= 1'b0;
      end else if (comp_wr) begin
         dirty_bits[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_mem[index] <= tag_in;
      end
      if (fill_wr | comp_wr) begin
         data_mem[index][word] <= data_in;
      end
   end

endmodule

`default_nettype wire

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire  [cache_geom_pkg::addr_bits-1:0]   addr,
   input  wire  [cache_geom_pkg::data_bits-1:0]   data_in,
   input  wire                                    rd,
   input  wire                                    wr,
   input  wire                                    way0_hit,
   input  wire                                    way0_valid,
   input  wire                                    way0_dirty,
   input  wire  [cache_geom_pkg::tag_bits-1:0]    way0_tag,
   input  wire  [cache_geom_pkg::data_bits-1:0]   way0_data,
   input  wire                                    way1_hit,
   input  wire                                    way1_valid,
   input  wire                                    way1_dirty,
   input  wire  [cache_geom_pkg::tag_bits-1:0]    way1_tag,
   input  wire  [cache_geom_pkg::data_bits-1:0]   way1_data,
   input  wire  [cache_geom_pkg::data_bits-1:0]   mem_rdata,
   output logic                                   way0_enable,
   output logic                                   way1_enable,
   output logic                                   comp,
   output logic                                   write,
   output logic [cache_geom_pkg::tag_bits-1:0]    tag_in,
   output logic [cache_geom_pkg::index_bits-1:0]  index,
   output logic [cache_geom_pkg::offset_bits-1:0] offset,
   output logic [cache_geom_pkg::data_bits-1:0]   way_data_in,
   output cache_ctrl_pkg::mem_cmd_t               mem_cmd,
   output logic [cache_geom_pkg::addr_bits-1:0]   mem_addr,
   output logic [cache_geom_pkg::data_bits-1:0]   mem_wdata,
   output logic [cache_geom_pkg::data_bits-1:0]   data_out,
   output logic                                   done,
   output logic                                   stall,
   output logic                                   cache_hit,
   output logic                                   req_err
);

   cache_ctrl_pkg::ctrl_state_t state, next_state;

   // Request held for the miss sequence
   logic [cache_geom_pkg::addr_bits-1:0]   req_addr;
   logic [cache_geom_pkg::data_bits-1:0]   req_data;
   logic                                   req_wr;
   logic                                   err_q;

   // Flags and read data from the last compare
   logic                                   hit0_q, hit1_q;
   logic                                   valid0_q, valid1_q;
   logic [cache_geom_pkg::data_bits-1:0]   data_q;
   logic                                   victim_bit;

   logic                                   req_any, req_bad;
   logic                                   accept_state, accept, compare_now;
   logic                                   real_hit, victim, writeback;
   logic [cache_geom_pkg::tag_bits-1:0]    victim_tag;
   logic [cache_geom_pkg::index_bits-1:0]  req_index;
   logic [cache_geom_pkg::addr_bits-cache_geom_pkg::offset_bits-1:0] req_line;

   // Byte offset of a word within the line
   function automatic logic [cache_geom_pkg::offset_bits-1:0] word_offset(
      input logic [cache_geom_pkg::word_sel_bits-1:0] w);
      return {w, 1'b0};
   endfunction

   assign req_any      = rd | wr;
   assign req_bad      = (rd & wr) | addr[0];
   assign accept_state = state inside {cache_ctrl_pkg::st_idle, cache_ctrl_pkg::st_compare,
                                       cache_ctrl_pkg::st_done};
   assign accept       = accept_state & req_any & ~req_bad;

   assign req_index = req_addr[cache_geom_pkg::offset_bits +: cache_geom_pkg::index_bits];
   assign req_line  = req_addr[cache_geom_pkg::addr_bits-1:cache_geom_pkg::offset_bits];

   // Invalid way first, way 0 before way 1, else the victim bit
   assign real_hit   = hit0_q | hit1_q;
   assign victim     = ~valid0_q ? 1'b0 : (~valid1_q ? 1'b1 : victim_bit);
   assign victim_tag = victim ? way1_tag : way0_tag;
   assign writeback  = victim ? (valid1_q & way1_dirty) : (valid0_q & way0_dirty);

   assign stall    = req_any & ~done;
   assign data_out = data_q;

   always_comb begin
      next_state  = state;
      way0_enable = 1'b0;
      way1_enable = 1'b0;
      comp        = 1'b0;
      write       = 1'b0;
      tag_in      = req_addr[cache_geom_pkg::addr_bits-1 -: cache_geom_pkg::tag_bits];
      index       = req_index;
      offset      = req_addr[cache_geom_pkg::offset_bits-1:0];
      way_data_in = req_data;
      mem_cmd     = cache_ctrl_pkg::mem_idle;
      mem_addr    = {req_line, word_offset(2'd0)};
      mem_wdata   = victim ? way1_data : way0_data;
      done        = 1'b0;
      cache_hit   = 1'b0;
      req_err     = 1'b0;
      compare_now = 1'b0;

      // New or repeated request, compared in the cycle it is seen
      if (accept_state) begin
         if (accept) begin
            way0_enable = 1'b1;
            way1_enable = 1'b1;
            comp        = 1'b1;
            write       = wr;
            tag_in      = addr[cache_geom_pkg::addr_bits-1 -: cache_geom_pkg::tag_bits];
            index       = addr[cache_geom_pkg::offset_bits +: cache_geom_pkg::index_bits];
            offset      = addr[cache_geom_pkg::offset_bits-1:0];
            way_data_in = data_in;
            compare_now = 1'b1;
            next_state  = cache_ctrl_pkg::st_check;
         end else begin
            next_state = req_any ? cache_ctrl_pkg::st_done : cache_ctrl_pkg::st_idle;
         end
      end

      // Victim line access during writeback and refill
      if (state inside {[cache_ctrl_pkg::st_evict_check : cache_ctrl_pkg::st_wb2],
                        [cache_ctrl_pkg::st_fill0 : cache_ctrl_pkg::st_fill3]}) begin
         way0_enable = ~victim;
         way1_enable = victim;
      end
      if (state inside {[cache_ctrl_pkg::st_fill0 : cache_ctrl_pkg::st_fill3]}) begin
         write       = 1'b1;
         way_data_in = mem_rdata;
      end

      case (state)
         cache_ctrl_pkg::st_check: begin
            if (real_hit) begin
               done       = 1'b1;
               cache_hit  = 1'b1;
               next_state = req_any ? cache_ctrl_pkg::st_compare : cache_ctrl_pkg::st_idle;
            end else begin
               next_state = cache_ctrl_pkg::st_evict_check;
            end
         end
         cache_ctrl_pkg::st_evict_check: begin
            offset = word_offset(2'd0);
            if (writeback) begin
               mem_cmd    = cache_ctrl_pkg::mem_write;
               mem_addr   = {victim_tag, req_index, word_offset(2'd0)};
               next_state = cache_ctrl_pkg::st_wb0;
            end else begin
               mem_cmd    = cache_ctrl_pkg::mem_read;
               next_state = cache_ctrl_pkg::st_rd1;
            end
         end
         cache_ctrl_pkg::st_wb0: begin
            offset     = word_offset(2'd1);
            mem_cmd    = cache_ctrl_pkg::mem_write;
            mem_addr   = {victim_tag, req_index, word_offset(2'd1)};
            next_state = cache_ctrl_pkg::st_wb1;
         end
         cache_ctrl_pkg::st_wb1: begin
            offset     = word_offset(2'd2);
            mem_cmd    = cache_ctrl_pkg::mem_write;
            mem_addr   = {victim_tag, req_index, word_offset(2'd2)};
            next_state = cache_ctrl_pkg::st_wb2;
         end
         cache_ctrl_pkg::st_wb2: begin
            offset     = word_offset(2'd3);
            mem_cmd    = cache_ctrl_pkg::mem_write;
            mem_addr   = {victim_tag, req_index, word_offset(2'd3)};
            next_state = cache_ctrl_pkg::st_rd_start;
         end
         cache_ctrl_pkg::st_rd_start: begin
            mem_cmd    = cache_ctrl_pkg::mem_read;
            next_state = cache_ctrl_pkg::st_rd1;
         end
         cache_ctrl_pkg::st_rd1: begin
            mem_cmd    = cache_ctrl_pkg::mem_read;
            mem_addr   = {req_line, word_offset(2'd1)};
            next_state = cache_ctrl_pkg::st_fill0;
         end
         // Word 0 returns while word 2 is requested
         cache_ctrl_pkg::st_fill0: begin
            offset     = word_offset(2'd0);
            mem_cmd    = cache_ctrl_pkg::mem_read;
            mem_addr   = {req_line, word_offset(2'd2)};
            next_state = cache_ctrl_pkg::st_fill1;
         end
         cache_ctrl_pkg::st_fill1: begin
            offset     = word_offset(2'd1);
            mem_cmd    = cache_ctrl_pkg::mem_read;
            mem_addr   = {req_line, word_offset(2'd3)};
            next_state = cache_ctrl_pkg::st_fill2;
         end
         cache_ctrl_pkg::st_fill2: begin
            offset     = word_offset(2'd2);
            next_state = cache_ctrl_pkg::st_fill3;
         end
         cache_ctrl_pkg::st_fill3: begin
            offset     = word_offset(2'd3);
            next_state = cache_ctrl_pkg::st_final_comp;
         end
         // Requested access on the refilled line
         cache_ctrl_pkg::st_final_comp: begin
            way0_enable = 1'b1;
            way1_enable = 1'b1;
            comp        = 1'b1;
            write       = req_wr;
            compare_now = 1'b1;
            next_state  = cache_ctrl_pkg::st_done;
         end
         cache_ctrl_pkg::st_done: begin
            done    = 1'b1;
            req_err = err_q;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= cache_ctrl_pkg::st_idle;
         victim_bit <= 1'b0;
         hit0_q     <= 1'b0;
         hit1_q     <= 1'b0;
         valid0_q   <= 1'b0;
         valid1_q   <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         state <= next_state;
         // Flip on each completed access
         if (done & ~req_err) begin
            victim_bit <= ~victim_bit;
         end
         if (compare_now) begin
            hit0_q   <= way0_hit;
            hit1_q   <= way1_hit;
            valid0_q <= way0_valid;
            valid1_q <= way1_valid;
         end
         if (accept_state) begin
            err_q <= req_any & req_bad;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
      if (compare_now) begin
         data_q <= way1_hit ? way1_data : way0_data;
      end
   end

endmodule

`default_nettype wire

//--- mem/four_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none

module four_bank_mem (
   input  wire                                  clk,
   input  wire                                  rst,
   input  wire cache_ctrl_pkg::mem_cmd_t        mem_cmd,
   input  wire  [cache_geom_pkg::addr_bits-1:0] mem_addr,
   input  wire  [cache_geom_pkg::data_bits-1:0] mem_wdata,
   output logic [cache_geom_pkg::data_bits-1:0] mem_rdata,
   output logic                                 mem_err
);

   // One bank per word of a line
   localparam int num_banks = cache_geom_pkg::line_words;
   localparam int row_bits  = cache_geom_pkg::addr_bits - cache_geom_pkg::offset_bits;
   localparam int cnt_bits  = $clog2(cache_geom_pkg::bank_busy_cycles + 1);
   localparam logic [cnt_bits-1:0] busy_load = cnt_bits'(cache_geom_pkg::bank_busy_cycles - 1);

   logic [cache_geom_pkg::data_bits-1:0] bank_mem [num_banks][2 ** row_bits];
   logic [cache_geom_pkg::mem_read_latency-1:0][cache_geom_pkg::data_bits-1:0] rd_pipe;
   logic [num_banks-1:0][cnt_bits-1:0]   busy_cnt;

   logic [cache_geom_pkg::word_sel_bits-1:0] bank;
   logic [row_bits-1:0]                      row;
   logic                                     active;

   assign bank      = mem_addr[cache_geom_pkg::offset_bits-1:1];
   assign row       = mem_addr[cache_geom_pkg::addr_bits-1:cache_geom_pkg::offset_bits];
   assign active    = mem_cmd != cache_ctrl_pkg::mem_idle;
   assign mem_rdata = rd_pipe[cache_geom_pkg::mem_read_latency-1];

   initial begin
      for (int b = 0; b < num_banks; b++) begin
         for (int r = 0; r < 2 ** row_bits; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   // Bank array and read pipeline
   always_ff @(posedge clk) begin
      if (mem_cmd == cache_ctrl_pkg::mem_write) begin
         bank_mem[bank][row] <= mem_wdata;
      end
      if (mem_cmd == cache_ctrl_pkg::mem_read) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      for (int i = 1; i < cache_geom_pkg::mem_read_latency; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // Busy count per bank, flag a command that hits an occupied bank
   always_ff @(posedge clk) begin
      if (rst) begin
         busy_cnt <= '0;
         mem_err  <= 1'b0;
      end else begin
         mem_err <= active & (busy_cnt[bank] != '0);
         for (int b = 0; b < num_banks; b++) begin
            if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - cnt_bits'(1);
            end
         end
         if (active) begin
            busy_cnt[bank] <= busy_load;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
   input  wire                                  clk,
   input  wire                                  rst,
   input  wire  [cache_geom_pkg::addr_bits-1:0] addr,
   input  wire  [cache_geom_pkg::data_bits-1:0] data_in,
   input  wire                                  rd,
   input  wire                                  wr,
   output logic [cache_geom_pkg::data_bits-1:0] data_out,
   output logic                                 done,
   output logic                                 stall,
   output logic                                 cache_hit,
   output logic                                 err
);

   // Shared way controls
   logic                                   way0_enable, way1_enable;
   logic                                   comp, way_write;
   logic [cache_geom_pkg::tag_bits-1:0]    tag_in;
   logic [cache_geom_pkg::index_bits-1:0]  index;
   logic [cache_geom_pkg::offset_bits-1:0] offset;
   logic [cache_geom_pkg::data_bits-1:0]   way_data_in;

   // Way outputs
   logic                                   way0_hit, way0_valid, way0_dirty;
   logic                                   way1_hit, way1_valid, way1_dirty;
   logic [cache_geom_pkg::tag_bits-1:0]    way0_tag, way1_tag;
   logic [cache_geom_pkg::data_bits-1:0]   way0_data, way1_data;

   // Memory side
   cache_ctrl_pkg::mem_cmd_t               mem_cmd;
   logic [cache_geom_pkg::addr_bits-1:0]   mem_addr;
   logic [cache_geom_pkg::data_bits-1:0]   mem_wdata, mem_rdata;
   logic                                   mem_err, req_err;

   assign err = req_err | mem_err;

   cache_way way0 (
      .clk(clk), .rst(rst), .enable(way0_enable), .comp(comp), .write(way_write),
      .tag_in(tag_in), .index(index), .offset(offset), .data_in(way_data_in),
      .data_out(way0_data), .tag_out(way0_tag), .hit(way0_hit), .valid(way0_valid),
      .dirty(way0_dirty)
   );

   cache_way way1 (
      .clk(clk), .rst(rst), .enable(way1_enable), .comp(comp), .write(way_write),
      .tag_in(tag_in), .index(index), .offset(offset), .data_in(way_data_in),
      .data_out(way1_data), .tag_out(way1_tag), .hit(way1_hit), .valid(way1_valid),
      .dirty(way1_dirty)
   );

   cache_ctrl ctrl (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .way0_hit(way0_hit), .way0_valid(way0_valid), .way0_dirty(way0_dirty),
      .way0_tag(way0_tag), .way0_data(way0_data),
      .way1_hit(way1_hit), .way1_valid(way1_valid), .way1_dirty(way1_dirty),
      .way1_tag(way1_tag), .way1_data(way1_data), .mem_rdata(mem_rdata),
      .way0_enable(way0_enable), .way1_enable(way1_enable), .comp(comp), .write(way_write),
      .tag_in(tag_in), .index(index), .offset(offset), .way_data_in(way_data_in),
      .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit),
      .req_err(req_err)
   );

   four_bank_mem mem (
      .clk(clk), .rst(rst), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_err(mem_err)
   );

endmodule

`default_nettype wire

//--- verif/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

   localparam int num_random   = 600;
   localparam int num_targeted = 6;
   // A dirty miss plus the idle gap stays well under 20 cycles
   localparam int max_cycles   = (num_random + num_targeted) * 20 + 100;

   logic        clk;
   logic        rst;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference model of memory contents and cache tags
   bit [15:0] ref_mem   [0:32767];
   bit [4:0]  ref_tag   [0:255][0:1];
   bit        ref_valid [0:255][0:1];
   bit        ref_victim;   // one victim bit shared by all sets

   logic [31:0] lfsr;
   int          cycle_count = 0;
   int          done_pulses = 0;
   int          requests = 0;

   mem_system dut (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Timeout: the run went past %0d cycles", max_cycles);
         $display("=== FAIL ===");
         $fatal(1, "Cycle limit reached");
      end
   end

   // Count every done pulse to catch spurious ones
   always @(negedge clk) begin
      if (!rst && done) begin
         done_pulses <= done_pulses + 1;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic stop_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_word(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   // Quiet cycles with no request held
   task automatic idle_cycles(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(negedge clk);
         check_bit("done", done, 1'b0);
         check_bit("stall", stall, 1'b0);
         check_bit("err", err, 1'b0);
         check_bit("cache_hit", cache_hit, 1'b0);
      end
   endtask

   // Hold one request until done, then check it against the model
   task automatic run_access(input logic do_rd, input logic do_wr,
                             input logic [15:0] a, input logic [15:0] d);
      logic        bad;
      logic        exp_hit;
      logic [15:0] exp_data;
      logic [7:0]  set;
      logic [4:0]  tag;
      int          way;
      int          i;
      bad      = (do_rd & do_wr) | a[0];
      set      = a[10:3];
      tag      = a[15:11];
      exp_data = ref_mem[a[15:1]];
      way      = -1;
      for (i = 0; i < 2; i++) begin
         if (ref_valid[set][i] && ref_tag[set][i] == tag) begin
            way = i;
         end
      end
      exp_hit = !bad && way >= 0;

      addr    = a;
      data_in = d;
      rd      = do_rd;
      wr      = do_wr;
      requests++;
      @(negedge clk);
      while (!done) begin
         check_bit("stall", stall, 1'b1);
         check_bit("err", err, 1'b0);
         @(negedge clk);
      end
      check_bit("stall", stall, 1'b0);
      check_bit("err", err, bad);
      check_bit("cache_hit", cache_hit, exp_hit);

      if (!bad) begin
         if (do_rd) begin
            check_word("data_out", data_out, exp_data);
         end
         // Invalid way first, way 0 before way 1, then the victim bit
         if (way < 0) begin
            if (!ref_valid[set][0]) begin
               way = 0;
            end else if (!ref_valid[set][1]) begin
               way = 1;
            end else begin
               way = ref_victim ? 1 : 0;
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
         end
         if (do_wr) begin
            ref_mem[a[15:1]] = d;
         end
         ref_victim = ~ref_victim;
      end
      rd = 1'b0;
      wr = 1'b0;
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] d;
      logic        do_rd;
      logic        do_wr;
      logic [4:0]  tag_r;
      logic [7:0]  set_r;
      logic [1:0]  word_r;
      int          n;
      clk        = 1'b0;
      rst        = 1'b1;
      addr       = '0;
      data_in    = '0;
      rd         = 1'b0;
      wr         = 1'b0;
      ref_victim = 1'b0;
      lfsr       = 32'hca89_707f;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      idle_cycles(10);

      for (n = 0; n < num_random; n++) begin
         do_wr  = rand_bits(1) != 0;
         do_rd  = ~do_wr;
         tag_r  = 5'(rand_bits(2));
         set_r  = 8'(rand_bits(2));
         word_r = 2'(rand_bits(2));
         d      = 16'(rand_bits(16));
         a      = {tag_r, set_r, word_r, 1'b0};
         // Roughly 1 in 20 is malformed
         if (rand_bits(8) < 13) begin
            if (rand_bits(1) != 0) begin
               a[0] = 1'b1;
            end else begin
               do_rd = 1'b1;
               do_wr = 1'b1;
            end
         end
         run_access(do_rd, do_wr, a, d);
         idle_cycles(int'(rand_bits(2)));
      end

      // Three tags on one set force evictions in two ways
      for (n = 0; n < 3; n++) begin
         a = {5'(9 + n), 8'd8, 3'd4};
         run_access(1'b0, 1'b1, a, 16'(rand_bits(16)));
         idle_cycles(1);
      end
      for (n = 0; n < 3; n++) begin
         a = {5'(9 + n), 8'd8, 3'd4};
         run_access(1'b1, 1'b0, a, 16'h0000);
         idle_cycles(1);
      end

      idle_cycles(4);
      assert (done_pulses == requests) else begin
         $display("Mismatch done pulses: got %h, expected %h", done_pulses, requests);
         stop_with_failure();
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
common/cache_geom_pkg.sv
common/cache_ctrl_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
mem/four_bank_mem.sv
src/mem_system.sv
verif/tb_mem_system.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_system \
   -f flist.f -o tb_mem_system_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_mem_system_sim > sim.log 2>&1 || true
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
